/* Bender.yml */
package:
  name: scv_video

sources:
  # RTL in compile order
  - src/scv_video_pkg.sv
  - src/video_timing.sv
  - src/bus_regs.sv
  - src/bg_fetch.sv
  - src/line_buffer.sv
  - src/pixel_out.sv
  - src/scv_video.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/scv_video_properties.sv
      - sim/scv_video_tb.sv

/* scv_video.f */
src/scv_video_pkg.sv
src/video_timing.sv
src/bus_regs.sv
src/bg_fetch.sv
src/line_buffer.sv
src/pixel_out.sv
src/scv_video.sv
sim/tb_clock.sv
sim/scv_video_properties.sv
sim/scv_video_tb.sv

/* sim/scv_video_properties.sv */
// Bound to scv_video; widths assume the 260-column raster and count CLK cycles
`default_nettype none
`timescale 1ns/1ps

module scv_video_properties (
  input logic                   CLK,
  input logic                   arst_n,
  input scv_video_pkg::wb_req_t wb_req,
  input scv_video_pkg::wb_rsp_t wb_rsp,
  input logic                   hs,
  input logic                   vs
);
  import scv_video_pkg::*;

  logic       stb_new;   // Strobe not yet acked
  logic [4:0] hs_len;
  logic [9:0] vs_len;

  assign stb_new = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;

  // Pulse width counters
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      hs_len <= '0;
      vs_len <= '0;
    end else begin
      hs_len <= hs ? hs_len + 5'd1 : '0;
      vs_len <= vs ? vs_len + 10'd1 : '0;
    end
  end

  //////////////////////////////////////////////////
  // Wishbone handshake

  ack_after_stb: assert property (@(posedge CLK) disable iff (!arst_n)
    stb_new |=> wb_rsp.ack)
    else $error("ack did not rise one cycle after stb");

  ack_needs_stb: assert property (@(posedge CLK) disable iff (!arst_n)
    wb_rsp.ack |-> $past(stb_new))
    else $error("ack rose without a pending strobe");

  ack_single: assert property (@(posedge CLK) disable iff (!arst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack stayed high for more than one cycle");

  //////////////////////////////////////////////////
  // Sync widths

  hs_width: assert property (@(posedge CLK) disable iff (!arst_n)
    $fell(hs) |-> (hs_len == 5'd20))
    else $error("HS pulse was not 20 cycles wide");

  vs_width: assert property (@(posedge CLK) disable iff (!arst_n)
    $fell(vs) |-> (vs_len == 10'd780))  // 3 lines of 260
    else $error("VS pulse was not 3 lines wide");

endmodule

`default_nettype wire

/* sim/scv_video_tb.sv */
// Run from the project root so sim/stimulus_input.txt is found; each frame check costs two frames
`default_nettype none
`timescale 1ns/1ps

module scv_video_tb;
  import scv_video_pkg::*;

  // Own copies of the raster geometry
  localparam int num_cols       = 260;
  localparam int num_rows       = 263;
  localparam int frame_cycles   = num_cols * num_rows;
  localparam int render_top     = 16;
  localparam int render_bottom  = 247;
  localparam int render_left    = 23;
  localparam int render_right   = 230;
  localparam int visible_top    = 18;
  localparam int visible_bottom = 247;
  localparam int visible_left   = 24;
  localparam int visible_right  = 227;
  localparam int vsync_row      = 257;
  localparam int hs_per_frame   = 263;
  localparam int de_per_frame   = 208 * 232;
  localparam int ack_limit      = 16;
  localparam int reset_limit    = 10;
  localparam int max_fail_lines = 40;  // Later mismatches are only counted
  localparam int num_cmds       = 64;

  logic        CLK;
  logic        arst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        hs, vs, vbl, de;
  rgb_t        rgb;
  logic [47:0] cmds [num_cmds];      // {op, adr[11:0], dat, count[23:0]}
  int          value_errors;
  int          other_errors;
  integer      seed;
  logic        aborted;              // A wait ran out, remaining commands are skipped

  tb_clock tb_clock_i (
    .CLK    (CLK),
    .arst_n (arst_n)
  );

  scv_video scv_video_i (
    .CLK    (CLK),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .hs     (hs),
    .vs     (vs),
    .vbl    (vbl),
    .de     (de),
    .rgb    (rgb)
  );

  bind scv_video scv_video_properties scv_video_properties_i (
    .CLK    (CLK),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .hs     (hs),
    .vs     (vs)
  );

  //////////////////////////////////////////////////
  // Reporting

  task automatic note_mismatch(input string msg);
    value_errors++;
    if (value_errors <= max_fail_lines) begin
      $display("Fail at %0d ns: %s", $time, msg);
    end
  endtask

  task automatic note_problem(input string msg);
    other_errors++;
    $display("%s, at %0d ns", msg, $time);
  endtask

  task automatic finish_run();
    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  function automatic rgb_t palette_rgb(input logic [3:0] idx);
    case (idx)
      4'd0:    return 24'h0000a0;
      4'd1:    return 24'h000000;
      4'd2:    return 24'h0000f5;
      4'd3:    return 24'ha000eb;
      4'd4:    return 24'h00f500;
      4'd5:    return 24'h96eb96;
      4'd6:    return 24'h00ebeb;
      4'd7:    return 24'h00a000;
      4'd8:    return 24'hf50000;
      4'd9:    return 24'heba000;
      4'd10:   return 24'heb00eb;
      4'd11:   return 24'heb9696;
      4'd12:   return 24'hebeb00;
      4'd13:   return 24'ha0a000;
      4'd14:   return 24'h969696;
      default: return 24'he1e1e1;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Wishbone master

  task automatic bus_access(input logic write, input logic [10:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
    int delay;
    rdat = 8'h00;
    if (aborted) begin
      return;
    end
    @(posedge CLK);
    #5;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = write;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    delay = 0;
    @(negedge CLK);
    while (!wb_rsp.ack && delay < ack_limit) begin
      @(negedge CLK);
      delay++;
    end
    rdat = wb_rsp.dat;
    if (!wb_rsp.ack) begin
      note_problem($sformatf("No ack from the bus for address 0x%03h", adr));
      aborted = 1'b1;
    end else begin
      assert (delay == 1)
        else note_mismatch($sformatf("ack %0d cycles after stb at 0x%03h", delay, adr));
      @(posedge CLK);
      #5;
      wb_req = '0;                           // stb drops in the cycle after ack
    end
  endtask

  task automatic write_byte(input logic [10:0] adr, input logic [7:0] dat);
    logic [7:0] discard;
    bus_access(1'b1, adr, dat, discard);
  endtask

  task automatic read_check(input logic [10:0] adr, input logic [7:0] expect_dat);
    logic [7:0] got;
    bus_access(1'b0, adr, 8'h00, got);
    if (!aborted) begin
      assert (got === expect_dat)
        else note_mismatch($sformatf("read 0x%02h at 0x%03h, expected 0x%02h",
                                     got, adr, expect_dat));
    end
  endtask

  task automatic fill_bgm(input logic [7:0] dat);
    for (int a = 0; a < 512 && !aborted; a++) begin
      write_byte(11'(a), dat);
    end
  endtask

  task automatic random_pairs(input int n);
    logic [31:0] rnd;
    logic [10:0] adr;
    logic [7:0]  dat;
    for (int i = 0; i < n && !aborted; i++) begin
      rnd = $random(seed);
      adr = {2'b00, rnd[8:0]};               // BGM only
      dat = rnd[23:16];
      write_byte(adr, dat);
      read_check(adr, dat);
    end
  endtask

  //////////////////////////////////////////////////
  // Raster checks

  task automatic wait_vs_rise(output logic found);
    logic prev;
    int   waited;
    found  = 1'b0;
    waited = 0;
    @(negedge CLK);
    prev = vs;
    while (!found && waited < 2 * frame_cycles) begin
      @(negedge CLK);
      waited++;
      found = vs && !prev;
      prev  = vs;
    end
  endtask

  // Counts one frame from VS rise to VS rise; visible pixels are count_idx or other_idx
  task automatic check_frame(input logic [3:0] count_idx, input logic [3:0] other_idx,
                             input int expect_count);
    int   r, c, cycles, hs_pulses, de_pixels, count_pixels;
    logic found, done, prev_vs, prev_hs, expect_de, expect_vbl, in_visible;
    rgb_t rgb_a, rgb_b;
    rgb_a = palette_rgb(count_idx);
    rgb_b = palette_rgb(other_idx);
    wait_vs_rise(found);
    if (!found) begin
      note_problem("No rising edge of VS within two frames");
      aborted = 1'b1;
    end else begin
      r = vsync_row;                         // Outputs now belong to row 257, column 0
      c = 0;
      cycles = 0;
      hs_pulses = 0;
      de_pixels = 0;
      count_pixels = 0;
      done = 1'b0;
      prev_vs = 1'b1;
      prev_hs = hs;
      while (!done && cycles < 2 * frame_cycles) begin
        expect_de  = (r >= render_top) && (r <= render_bottom) &&
                     (c >= render_left) && (c <= render_right);
        expect_vbl = (r < render_top) || (r > render_bottom);
        in_visible = (r >= visible_top) && (r <= visible_bottom) &&
                     (c >= visible_left) && (c <= visible_right);
        assert (de === expect_de)
          else note_mismatch($sformatf("DE is %b at row %0d col %0d", de, r, c));
        assert (vbl === expect_vbl)
          else note_mismatch($sformatf("VBL is %b at row %0d col %0d", vbl, r, c));
        if (de === 1'b1) begin
          de_pixels++;
          if (in_visible && rgb === rgb_a) begin
            count_pixels++;
          end else if (in_visible) begin
            assert (rgb === rgb_b)
              else note_mismatch($sformatf(
                "pixel %06h at row %0d col %0d, expected %06h or %06h", rgb, r, c, rgb_a, rgb_b));
          end else begin
            assert (rgb === 24'h000000)
              else note_mismatch($sformatf("border pixel %06h at row %0d col %0d", rgb, r, c));
          end
        end
        if (hs && !prev_hs) begin
          hs_pulses++;
        end
        prev_hs = hs;
        c++;
        if (c == num_cols) begin
          c = 0;
          r = (r == num_rows - 1) ? 0 : r + 1;
        end
        cycles++;
        @(negedge CLK);
        done    = vs && !prev_vs;
        prev_vs = vs;
      end
      if (!done) begin
        note_problem("No second rising edge of VS within two frames");
        aborted = 1'b1;
      end else begin
        assert (cycles == frame_cycles)
          else note_mismatch($sformatf("frame of %0d cycles", cycles));
        assert (hs_pulses == hs_per_frame)
          else note_mismatch($sformatf("%0d HS pulses in a frame", hs_pulses));
        assert (de_pixels == de_per_frame)
          else note_mismatch($sformatf("%0d DE pixels in a frame", de_pixels));
        assert (count_pixels == expect_count)
          else note_mismatch($sformatf("%0d pixels of colour %0d, expected %0d",
                                       count_pixels, count_idx, expect_count));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Command sequencer

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (arst_n !== 1'b1 && waited < reset_limit) begin
      @(negedge CLK);
      assert (hs === 1'b0 && vs === 1'b0 && de === 1'b0)
        else note_mismatch("HS, VS or DE high during reset");
      waited++;
    end
    if (arst_n !== 1'b1) begin
      note_problem("Reset was never released");
      aborted = 1'b1;
    end
  endtask

  task automatic run_commands();
    logic [3:0]  op;
    logic [11:0] adr;
    logic [7:0]  dat;
    logic [23:0] cnt;
    int          i;
    i = 0;
    if (cmds[0][47:44] == 4'h0) begin
      note_problem("The stimulus file sim/stimulus_input.txt is empty or missing");
    end
    while (!aborted && i < num_cmds && cmds[i][47:44] != 4'h0) begin
      {op, adr, dat, cnt} = cmds[i];
      case (op)
        4'h1:    write_byte(adr[10:0], dat);
        4'h2:    read_check(adr[10:0], dat);
        4'h3:    fill_bgm(dat);
        4'h4:    random_pairs(int'(cnt));
        4'h5:    check_frame(dat[3:0], dat[7:4], int'(cnt));
        default: note_problem($sformatf("Unknown command %0h in stimulus entry %0d", op, i));
      endcase
      i++;
    end
  endtask

  initial begin
    wb_req       = '0;
    value_errors = 0;
    other_errors = 0;
    aborted      = 1'b0;
    seed         = 40;
    foreach (cmds[k]) begin
      cmds[k] = '0;
    end
    $readmemh("sim/stimulus_input.txt", cmds);
    wait_reset_release();
    run_commands();
    finish_run();
  end

endmodule

`default_nettype wire

/* sim/stimulus_input.txt */
// Hex entries op_adr_dat_count: op 1 write, 2 read and compare with dat, 3 fill BGM with dat,
// 4 count random BGM write/read pairs, 5 frame check, dat = {other colour, counted colour}
// Registers read zero after reset
2_200_00_000000
2_201_00_000000
// Register 0 keeps bits 1:0 only
1_200_ff_000000
2_200_03_000000
1_200_02_000000
2_200_02_000000
1_201_5a_000000
2_201_5a_000000
1_202_c3_000000
2_202_c3_000000
1_203_3c_000000
2_203_3c_000000
// Random BGM bytes
4_000_00_000020
// Bitmap off, bg 12, fg 3, 204 x 230 visible pixels
1_200_00_000000
1_201_3c_000000
5_000_cc_00b748
// Low resolution, nibble 5 everywhere
3_000_55_000000
1_200_03_000000
2_1ff_55_000000
5_000_55_00b748
// Low resolution, nibble 0 shows bg
3_000_00_000000
5_000_cc_00b748
// High resolution, all bits set
3_000_ff_000000
1_200_01_000000
5_000_33_00b748
// High resolution 0xAA, left half of each tile fg
3_000_aa_000000
5_000_c3_005ba4

/* sim/tb_clock.sv */
// Free-running 100 ns clock from time 0; arst_n releases 5 ns after the third rising edge
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic arst_n
);

  localparam int reset_cycles = 3;

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;                  // 100 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    #5 arst_n = 1'b1;                        // Same offset as the bus stimulus
  end

endmodule

`default_nettype wire

/* src/bg_fetch.sv */
// Fetches one line ahead in 34 cycles after line_start; row must hold still during the fetch
`default_nettype none
`timescale 1ns/1ps

module bg_fetch (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     line_start,
  input  scv_video_pkg::raster_t   row,
  input  scv_video_pkg::ctrl_t     ctrl,
  output scv_video_pkg::bgm_addr_t bgm_raddr,
  input  logic [7:0]               bgm_rdata,
  output logic                     lb_we,
  output logic                     lb_wsel,
  output scv_video_pkg::tile_t     lb_wtile,
  output scv_video_pkg::px_word_t  lb_wdata
);
  import scv_video_pkg::*;

  fetch_st_t  state;
  tile_t      tile_cnt;
  tile_t      rd_tile;     // Tile of the read in flight
  logic       rd_vld;
  raster_t    line_row;    // Bitmap row of the line being fetched
  logic [2:0] hi_pos;
  logic [1:0] hi_bits;
  logic [7:0] hi_mask;
  logic [3:0] lo_nib;
  px_word_t   px_word;

  assign line_row  = row + 9'd1 - first_row_render;
  assign bgm_raddr = {line_row[7:4], tile_cnt};  // 32 bytes per 16-row band

  //////////////////////////////////////////////////
  // Fetch sequencer

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      tile_cnt <= '0;
      rd_vld   <= 1'b0;
    end else begin
      rd_vld <= (state == FETCH);
      case (state)
        IDLE: begin
          if (line_start) begin
            state    <= FETCH;
            tile_cnt <= '0;
          end
        end
        FETCH: begin
          tile_cnt <= tile_cnt + 5'd1;
          if (tile_cnt == 5'd31) begin
            state <= DONE;
          end
        end
        default: begin
          // Wait for the last read to drain
          if (!rd_vld) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    rd_tile <= tile_cnt;
  end

  //////////////////////////////////////////////////
  // Byte to pixel expansion

  assign hi_pos  = {~line_row[3:2], 1'b0};       // Field at 6 - 2 * row[3:2]
  assign hi_bits = bgm_rdata[hi_pos +: 2];
  assign hi_mask = {{4{hi_bits[0]}}, {4{hi_bits[1]}}};  // High bit covers the left half
  assign lo_nib  = line_row[3] ? bgm_rdata[3:0] : bgm_rdata[7:4];

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      if (!ctrl.bm_ena) begin
        px_word[i*4 +: 4] = ctrl.bg_color;
      end else if (ctrl.bm_lores) begin
        px_word[i*4 +: 4] = (lo_nib != 4'd0) ? lo_nib : ctrl.bg_color;  // Zero is transparent
      end else begin
        px_word[i*4 +: 4] = hi_mask[i] ? ctrl.fg_color : ctrl.bg_color;
      end
    end
  end

  //////////////////////////////////////////////////
  // Line buffer write, two cycles after the read

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      lb_we <= 1'b0;
    end else begin
      lb_we <= rd_vld;
    end
  end

  always_ff @(posedge CLK) begin
    lb_wtile <= rd_tile;
    lb_wdata <= px_word;
    lb_wsel  <= ~row[0];                     // Half that the next row reads
  end

endmodule

`default_nettype wire

/* src/bus_regs.sv */
// Wishbone classic slave, ack one cycle after stb; addresses 0x204-0x7FF ack and read as zero
`default_nettype none
`timescale 1ns/1ps

module bus_regs (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  scv_video_pkg::wb_req_t   wb_req,
  output scv_video_pkg::wb_rsp_t   wb_rsp,
  output scv_video_pkg::ctrl_t     ctrl,
  input  scv_video_pkg::bgm_addr_t bgm_raddr,
  output logic [7:0]               bgm_rdata
);
  import scv_video_pkg::*;

  logic [7:0] bgm [512];
  logic       req;          // New access, not yet acked
  logic       wr;
  logic       sel_bgm;
  logic       sel_reg;
  logic       ack_q;
  logic       sel_bgm_q;
  logic [7:0] bgm_q;
  logic [7:0] reg_q;
  logic [7:0] reg_rdat;
  ctrl_t      ctrl_q;
  logic [7:0] reg2_q, reg3_q;  // Kept for read back only

  //////////////////////////////////////////////////
  // Address decode and handshake

  assign req     = wb_req.cyc & wb_req.stb & ~ack_q;
  assign wr      = req & wb_req.we;
  assign sel_bgm = (wb_req.adr[10:9] == 2'b00);  // 0x000 - 0x1FF
  assign sel_reg = (wb_req.adr[10:2] == 9'h080); // 0x200 - 0x203

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  //////////////////////////////////////////////////
  // Control registers

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
      reg2_q <= '0;
      reg3_q <= '0;
    end else if (wr && sel_reg) begin
      case (wb_req.adr[1:0])
        2'd0: begin
          ctrl_q.bm_ena   <= wb_req.dat[0];
          ctrl_q.bm_lores <= wb_req.dat[1];
        end
        2'd1: begin
          ctrl_q.bg_color <= wb_req.dat[3:0];
          ctrl_q.fg_color <= wb_req.dat[7:4];
        end
        2'd2: reg2_q <= wb_req.dat;
        default: reg3_q <= wb_req.dat;
      endcase
    end
  end

  always_comb begin
    case (wb_req.adr[1:0])
      2'd0: reg_rdat = {6'b0, ctrl_q.bm_lores, ctrl_q.bm_ena};
      2'd1: reg_rdat = {ctrl_q.fg_color, ctrl_q.bg_color};
      2'd2: reg_rdat = reg2_q;
      default: reg_rdat = reg3_q;
    endcase
  end

  assign ctrl = ctrl_q;

  //////////////////////////////////////////////////
  // Background memory, bus port and render port

  always_ff @(posedge CLK) begin
    if (wr && sel_bgm) begin
      bgm[wb_req.adr[8:0]] <= wb_req.dat;
    end
    bgm_q <= bgm[wb_req.adr[8:0]];
  end

  always_ff @(posedge CLK) begin
    bgm_rdata <= bgm[bgm_raddr];             // One cycle read latency
  end

  // Read data is captured with the cycle that raises ack
  always_ff @(posedge CLK) begin
    if (req) begin
      sel_bgm_q <= sel_bgm;
      reg_q     <= sel_reg ? reg_rdat : 8'h00;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = sel_bgm_q ? bgm_q : reg_q;

endmodule

`default_nettype wire

/* src/line_buffer.sv */
// Two 32-word halves; writer and reader must select different halves in any one cycle
`default_nettype none
`timescale 1ns/1ps

module line_buffer (
  input  logic                    CLK,
  input  logic                    we,
  input  logic                    wsel,
  input  scv_video_pkg::tile_t    wtile,
  input  scv_video_pkg::px_word_t wdata,
  input  logic                    rsel,
  input  scv_video_pkg::tile_t    rtile,
  output scv_video_pkg::px_word_t rdata
);
  import scv_video_pkg::*;

  px_word_t rd_q [2];
  logic     rsel_q;

  // One simple dual-port memory per half
  for (genvar g = 0; g < 2; g++) begin : g_half
    px_word_t mem [32];

    always_ff @(posedge CLK) begin
      if (we && (wsel == 1'(g))) begin
        mem[wtile] <= wdata;
      end
      rd_q[g] <= mem[rtile];
    end
  end

  always_ff @(posedge CLK) begin
    rsel_q <= rsel;
  end

  assign rdata = rsel_q ? rd_q[1] : rd_q[0];

endmodule

`default_nettype wire

/* src/pixel_out.sv */
// RGB palette only; expects de_in and visible one cycle after the counters, gives RGB at three
`default_nettype none
`timescale 1ns/1ps

module pixel_out (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  scv_video_pkg::raster_t  row,
  input  scv_video_pkg::raster_t  col,
  input  logic                    de_in,
  input  logic                    visible,
  output logic                    lb_rsel,
  output scv_video_pkg::tile_t    lb_rtile,
  input  scv_video_pkg::px_word_t lb_rdata,
  output scv_video_pkg::rgb_t     rgb,
  output logic                    de
);
  import scv_video_pkg::*;

  raster_t    lb_col;
  logic [2:0] px_sel_q;
  color_idx_t px_idx;
  color_idx_t idx_q;
  logic       de_q;
  rgb_t       pal;

  //////////////////////////////////////////////////
  // Line buffer read

  assign lb_col   = col - fetch_col_offset;
  assign lb_rtile = lb_col[7:3];
  assign lb_rsel  = row[0];

  always_ff @(posedge CLK) begin
    px_sel_q <= lb_col[2:0];
  end

  // Black outside the visible window
  assign px_idx = visible ? lb_rdata[px_sel_q*4 +: 4] : 4'd1;

  always_ff @(posedge CLK) begin
    idx_q <= px_idx;
    rgb   <= pal;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      de_q <= 1'b0;
      de   <= 1'b0;
    end else begin
      de_q <= de_in;
      de   <= de_q;
    end
  end

  //////////////////////////////////////////////////
  // Palette

  always_comb begin
    case (idx_q)
      4'd0:  pal = {8'd0,   8'd0,   8'd160};
      4'd1:  pal = {8'd0,   8'd0,   8'd0};
      4'd2:  pal = {8'd0,   8'd0,   8'd245};
      4'd3:  pal = {8'd160, 8'd0,   8'd235};
      4'd4:  pal = {8'd0,   8'd245, 8'd0};
      4'd5:  pal = {8'd150, 8'd235, 8'd150};
      4'd6:  pal = {8'd0,   8'd235, 8'd235};
      4'd7:  pal = {8'd0,   8'd160, 8'd0};
      4'd8:  pal = {8'd245, 8'd0,   8'd0};
      4'd9:  pal = {8'd235, 8'd160, 8'd0};
      4'd10: pal = {8'd235, 8'd0,   8'd235};
      4'd11: pal = {8'd235, 8'd150, 8'd150};
      4'd12: pal = {8'd235, 8'd235, 8'd0};
      4'd13: pal = {8'd160, 8'd160, 8'd0};
      4'd14: pal = {8'd150, 8'd150, 8'd150};
      default: pal = {8'd225, 8'd225, 8'd225};
    endcase
  end

endmodule

`default_nettype wire

/* src/scv_video.sv */
// Bitmap background only; RGB, DE and syncs all lag their raster position by three cycles
`default_nettype none
`timescale 1ns/1ps

module scv_video (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  scv_video_pkg::wb_req_t wb_req,
  output scv_video_pkg::wb_rsp_t wb_rsp,
  output logic                   hs,
  output logic                   vs,
  output logic                   vbl,
  output logic                   de,
  output scv_video_pkg::rgb_t    rgb
);
  import scv_video_pkg::*;

  raster_t    row, col;
  logic       line_start;
  logic       tm_de;       // Render window, one cycle after the counters
  logic       tm_visible;
  ctrl_t      ctrl;
  bgm_addr_t  bgm_raddr;
  logic [7:0] bgm_rdata;
  logic       lb_we, lb_wsel, lb_rsel;
  tile_t      lb_wtile, lb_rtile;
  px_word_t   lb_wdata, lb_rdata;

  video_timing video_timing_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .row        (row),
    .col        (col),
    .line_start (line_start),
    .hs         (hs),
    .vs         (vs),
    .vbl        (vbl),
    .de         (tm_de),
    .visible    (tm_visible)
  );

  bus_regs bus_regs_i (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .ctrl      (ctrl),
    .bgm_raddr (bgm_raddr),
    .bgm_rdata (bgm_rdata)
  );

  bg_fetch bg_fetch_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .line_start (line_start),
    .row        (row),
    .ctrl       (ctrl),
    .bgm_raddr  (bgm_raddr),
    .bgm_rdata  (bgm_rdata),
    .lb_we      (lb_we),
    .lb_wsel    (lb_wsel),
    .lb_wtile   (lb_wtile),
    .lb_wdata   (lb_wdata)
  );

  line_buffer line_buffer_i (
    .CLK   (CLK),
    .we    (lb_we),
    .wsel  (lb_wsel),
    .wtile (lb_wtile),
    .wdata (lb_wdata),
    .rsel  (lb_rsel),
    .rtile (lb_rtile),
    .rdata (lb_rdata)
  );

  pixel_out pixel_out_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .row      (row),
    .col      (col),
    .de_in    (tm_de),
    .visible  (tm_visible),
    .lb_rsel  (lb_rsel),
    .lb_rtile (lb_rtile),
    .lb_rdata (lb_rdata),
    .rgb      (rgb),
    .de       (de)
  );

endmodule

`default_nettype wire

/* src/scv_video_pkg.sv */
// Shared raster geometry, bus records and pixel types; the geometry assumes one pixel per CLK
`default_nettype none

package scv_video_pkg;

  //////////////////////////////////////////////////
  // Vector types

  typedef logic [8:0]  raster_t;     // Row or column number
  typedef logic [3:0]  color_idx_t;  // Palette index
  typedef logic [23:0] rgb_t;        // {R, G, B}
  typedef logic [8:0]  bgm_addr_t;   // Byte address into BGM
  typedef logic [4:0]  tile_t;       // 32 tiles of 8 pixels
  typedef logic [31:0] px_word_t;    // 8 pixels, leftmost in the low nibble

  //////////////////////////////////////////////////
  // Measured raster geometry

  localparam raster_t num_cols = 9'd260;
  localparam raster_t num_rows = 9'd263;

  // Render window, 208 x 232 including overscan
  localparam raster_t first_row_render = 9'd16;
  localparam raster_t last_row_render  = 9'd247;
  localparam raster_t first_col_render = 9'd23;
  localparam raster_t last_col_render  = 9'd230;

  // Visible window, 204 x 230, hides the ragged render edges
  localparam raster_t first_row_visible = 9'd18;
  localparam raster_t last_row_visible  = 9'd247;
  localparam raster_t first_col_visible = 9'd24;
  localparam raster_t last_col_visible  = 9'd227;

  localparam raster_t first_col_hsync = 9'd240;
  localparam raster_t last_col_hsync  = 9'd259;
  localparam raster_t first_row_vsync = 9'd257;
  localparam raster_t last_row_vsync  = 9'd259;

  // Column count minus this gives the line buffer column
  localparam raster_t fetch_col_offset = 9'd6;

  //////////////////////////////////////////////////
  // Bus and control records

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [10:0] adr;
    logic [7:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic       bm_ena;    // Bitmap enable
    logic       bm_lores;  // 1 = low resolution
    color_idx_t bg_color;
    color_idx_t fg_color;  // High resolution only
  } ctrl_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DONE
  } fetch_st_t;

endpackage

`default_nettype wire

/* src/video_timing.sv */
// Free-running 260x263 raster; HS/VS/VBL leave 3 cycles after their count, DE/visible after 1
`default_nettype none
`timescale 1ns/1ps

module video_timing (
  input  logic                   CLK,
  input  logic                   arst_n,
  output scv_video_pkg::raster_t row,
  output scv_video_pkg::raster_t col,
  output logic                   line_start,
  output logic                   hs,
  output logic                   vs,
  output logic                   vbl,
  output logic                   de,
  output logic                   visible
);
  import scv_video_pkg::*;

  logic       render_row, render_col;
  logic       visible_row, visible_col;
  logic [2:0] sync_p;                        // {hs, vs, vbl} decoded from the counters
  logic [2:0] sync_d1, sync_d2, sync_d3;

  //////////////////////////////////////////////////
  // Raster counters

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      row <= '0;
      col <= '0;
    end else if (col == num_cols - 9'd1) begin
      col <= '0;
      row <= (row == num_rows - 9'd1) ? '0 : row + 9'd1;
    end else begin
      col <= col + 9'd1;
    end
  end

  //////////////////////////////////////////////////
  // Window decode

  assign render_row  = (row >= first_row_render) && (row <= last_row_render);
  assign render_col  = (col >= first_col_render) && (col <= last_col_render);
  assign visible_row = (row >= first_row_visible) && (row <= last_row_visible);
  assign visible_col = (col >= first_col_visible) && (col <= last_col_visible);

  assign sync_p[2] = (col >= first_col_hsync) && (col <= last_col_hsync);
  assign sync_p[1] = (row >= first_row_vsync) && (row <= last_row_vsync);
  assign sync_p[0] = ~render_row;

  // Fetch runs one line ahead, so it starts two rows above the render window
  assign line_start = (col == '0) && (row >= first_row_render - 9'd2) &&
                      (row <= last_row_render);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      de      <= 1'b0;
      visible <= 1'b0;
      sync_d1 <= '0;
      sync_d2 <= '0;
      sync_d3 <= '0;
    end else begin
      de      <= render_row & render_col;
      visible <= visible_row & visible_col;
      sync_d1 <= sync_p;
      sync_d2 <= sync_d1;                    // Two more stages to match the pixel pipeline
      sync_d3 <= sync_d2;
    end
  end

  assign hs  = sync_d3[2];
  assign vs  = sync_d3[1];
  assign vbl = sync_d3[0];

endmodule

`default_nettype wire
